// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv64_alu
FLIST     ?= rv64_alu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -Fxq "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)

// ==== alu_core.sv ====
`timescale 1ns/1ps

module alu_core
    import rv64_alu_pkg::*;
(
    input  alu_op_e         op_i,
    input  logic            word_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    output logic [XLEN-1:0] res_o,
    output logic            less_o,
    output logic            zero_o
);

    logic            sub;
    logic            unsigned_cmp;
    logic [XLEN-1:0] src2_inv;
    logic [XLEN-1:0] sum;
    logic            carry;
    logic            overflow;
    logic            less;
    logic [XLEN-1:0] shift_res;
    logic [XLEN-1:0] alu_out;

    // compares go through the adder as a subtract
    assign sub          = (op_i == ALU_SUB) || (op_i == ALU_SLT) || (op_i == ALU_SLTU);
    assign unsigned_cmp = (op_i == ALU_SLTU);

    // a - b as a + ~b + 1
    assign src2_inv = src2_i ^ {XLEN{sub}};

    assign {carry, sum} = {1'b0, src1_i} + {1'b0, src2_inv} + {{XLEN{1'b0}}, sub};

    assign overflow = (src1_i[XLEN-1] == src2_inv[XLEN-1]) &&
                      (sum[XLEN-1] != src1_i[XLEN-1]);

    // no borrow out means src1 >= src2 for unsigned
    assign less = unsigned_cmp ? (carry ^ sub) : (sum[XLEN-1] ^ overflow);

    assign less_o = less;
    assign zero_o = ~|sum;

    alu_shifter u_alu_shifter (
        .op_i    (op_i),
        .word_i  (word_i),
        .src_i   (src1_i),
        .shamt_i (src2_i[5:0]),
        .shift_o (shift_res)
    );

    // output select
    always_comb begin
        case (op_i)
            ALU_ADD,
            ALU_SUB: begin
                alu_out = sum;
            end
            ALU_SLL,
            ALU_SRL,
            ALU_SRA: begin
                alu_out = shift_res;
            end
            ALU_SLT,
            ALU_SLTU: begin
                alu_out = {{(XLEN-1){1'b0}}, less};
            end
            ALU_SRC2: begin
                alu_out = src2_i;
            end
            ALU_XOR: begin
                alu_out = src1_i ^ src2_i;
            end
            ALU_OR: begin
                alu_out = src1_i | src2_i;
            end
            ALU_AND: begin
                alu_out = src1_i & src2_i;
            end
            default: begin
                alu_out = sum;
            end
        endcase
    end

    // W forms keep the low word and sign-extend it
    assign res_o = word_i ? {{(XLEN-32){alu_out[31]}}, alu_out[31:0]} : alu_out;

endmodule

// ==== alu_shifter.sv ====
`timescale 1ns/1ps

module alu_shifter
    import rv64_alu_pkg::*;
(
    input  alu_op_e         op_i,
    input  logic            word_i,
    input  logic [XLEN-1:0] src_i,
    input  logic [5:0]      shamt_i,
    output logic [XLEN-1:0] shift_o
);

    logic            right;
    logic            arith;
    logic [5:0]      amt;
    logic [XLEN-1:0] shin;
    logic [XLEN-1:0] shr;
    logic [XLEN-1:0] mask;
    logic [XLEN-1:0] mask_w;
    logic [XLEN-1:0] srl_res;
    logic [XLEN-1:0] sra_res;
    logic [XLEN-1:0] fill;
    logic            sign;

    function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] r;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = v[XLEN-1-i];
        end
        return r;
    endfunction

    assign right = (op_i == ALU_SRL) || (op_i == ALU_SRA);
    assign arith = (op_i == ALU_SRA);

    // W forms only look at five shift bits
    assign amt = word_i ? {1'b0, shamt_i[4:0]} : shamt_i;

    // left shift runs through the same right shifter on reversed bits
    assign shin = right ? src_i : bit_rev(src_i);
    assign shr  = shin >> amt;

    // ones where shifted data landed
    assign mask   = {XLEN{1'b1}} >> amt;
    assign mask_w = {{(XLEN-32){1'b0}}, mask[XLEN-1:32]};

    // upper word bits leak into the low word in W mode, clear them
    assign srl_res = word_i ? (shr & mask_w) : shr;

    assign sign    = word_i ? src_i[31] : src_i[XLEN-1];
    assign fill    = word_i ? {{(XLEN-32){1'b0}}, ~mask[XLEN-1:32]} : ~mask;
    assign sra_res = srl_res | ({XLEN{sign}} & fill);

    assign shift_o = right ? (arith ? sra_res : srl_res) : bit_rev(shr);

endmodule

// ==== mul_finish.sv ====
`timescale 1ns/1ps

module mul_finish
    import rv64_alu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush_i,
    input  mul_pipe_t       pipe_i,
    output logic [XLEN-1:0] result_o,
    output logic            done_o
);

    logic              in_valid_q;
    mul_pipe_t         in_q;
    logic [PROD_W-1:0] prod;
    logic [XLEN-1:0]   sel;
    logic [XLEN-1:0]   res_d;
    logic [XLEN-1:0]   result_q;
    logic              done_q;

    // input stage, drops the product on flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= pipe_i.valid && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_i.valid) begin
            in_q <= pipe_i;
        end
    end

    // sign fix on the full product, then pick the half
    assign prod  = in_q.neg ? -in_q.acc : in_q.acc;
    assign sel   = (in_q.op == MUL_LO) ? prod[XLEN-1:0] : prod[PROD_W-1:XLEN];
    assign res_d = in_q.word ? {{(XLEN-32){sel[31]}}, sel[31:0]} : sel;

    // result holds the last product until the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q   <= 1'b0;
            result_q <= '0;
        end else begin
            done_q <= in_valid_q && !flush_i;
            if (in_valid_q && !flush_i) begin
                result_q <= res_d;
            end
        end
    end

    assign result_o = result_q;
    assign done_o   = done_q;

endmodule

// ==== mul_prep.sv ====
`timescale 1ns/1ps

module mul_prep
    import rv64_alu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en_i,
    input  mul_op_e         op_i,
    input  logic            word_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    input  logic            flush_i,
    output mul_pipe_t       pipe_o
);

    logic [XLEN-1:0] src1_q;
    logic [XLEN-1:0] src2_q;
    mul_op_e         op_q;
    logic            word_q;
    logic            pending_q;
    logic            diff;
    logic            issue;
    logic            s1_neg;
    logic            s2_neg;
    logic            valid_q;
    mul_pipe_t       pay_d;
    mul_pipe_t       pay_q;

    // new request when anything differs from the locked copy
    assign diff  = (src1_i != src1_q) || (src2_i != src2_q) ||
                   (op_i != op_q) || (word_i != word_q);
    assign issue = en_i && (diff || pending_q);

    // operand lock, pending allows a reissue of the same operands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src1_q    <= '0;
            src2_q    <= '0;
            op_q      <= MUL_LO;
            word_q    <= 1'b0;
            pending_q <= 1'b1;
        end else begin
            if (issue) begin
                src1_q <= src1_i;
                src2_q <= src2_i;
                op_q   <= op_i;
                word_q <= word_i;
            end
            if (flush_i) begin
                pending_q <= 1'b1;
            end else if (issue) begin
                pending_q <= 1'b0;
            end
        end
    end

    // src1 is signed except for mulhu, src2 only for mul and mulh
    assign s1_neg = (op_i != MUL_HUU) && src1_i[XLEN-1];
    assign s2_neg = ((op_i == MUL_LO) || (op_i == MUL_HSS)) && src2_i[XLEN-1];

    always_comb begin
        pay_d        = '0;
        pay_d.valid  = 1'b1;
        pay_d.op     = op_i;
        pay_d.word   = word_i;
        pay_d.neg    = s1_neg ^ s2_neg;
        pay_d.mcand  = s1_neg ? -src1_i : src1_i;
        pay_d.mplier = s2_neg ? -src2_i : src2_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            pay_q <= pay_d;
        end
    end

    always_comb begin
        pipe_o       = pay_q;
        pipe_o.valid = valid_q;
    end

endmodule

// ==== mul_stage.sv ====
`timescale 1ns/1ps

module mul_stage
    import rv64_alu_pkg::*;
#(
    // must divide XLEN evenly
    parameter int NUM_STAGES = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush_i,
    input  mul_pipe_t pipe_i,
    output mul_pipe_t pipe_o
);

    // multiplier bits handled by this stage
    localparam int BITS = XLEN / NUM_STAGES;

    mul_pipe_t     nxt;
    logic [XLEN:0] upper;
    logic          valid_q;
    mul_pipe_t     pay_q;

    // shift-add, one multiplier bit per step
    // acc moves right instead of the multiplicand moving left,
    // so the multiplicand always adds into the upper half
    always_comb begin
        nxt   = pipe_i;
        upper = '0;
        for (int i = 0; i < BITS; i++) begin
            upper = {1'b0, nxt.acc[PROD_W-1:XLEN]} +
                    (nxt.mplier[0] ? {1'b0, nxt.mcand} : {(XLEN+1){1'b0}});
            nxt.acc    = {upper, nxt.acc[XLEN-1:1]};
            nxt.mplier = nxt.mplier >> 1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pipe_i.valid && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_i.valid) begin
            pay_q <= nxt;
        end
    end

    always_comb begin
        pipe_o       = pay_q;
        pipe_o.valid = valid_q;
    end

endmodule

// ==== rv64_alu.f ====
rv64_alu_pkg.sv
alu_shifter.sv
alu_core.sv
mul_prep.sv
mul_stage.sv
mul_finish.sv
rv64_alu_top.sv
rv64_alu_assertions.sv
tb_rv64_alu.sv

// ==== rv64_alu_assertions.sv ====
`timescale 1ns/1ps

module rv64_alu_assertions
    import rv64_alu_pkg::*;
#(
    parameter int NUM_STAGES = 4
) (
    input logic            clk,
    input logic            rst_n,
    input logic            flush_i,
    input logic            issued_i,
    input logic            mul_done_i,
    input logic [XLEN-1:0] res_i,
    input logic            less_i,
    input logic            zero_i
);

    localparam int LATENCY = NUM_STAGES + 2;

    // issued_i is the prep stage valid, high in the cycle after an issue edge
    a_done_pairs: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mul_done_i && $past(mul_done_i)) |->
            ($past(issued_i, LATENCY) && $past(issued_i, LATENCY + 1))
    ) else $error("two done pulses in a row without two issues in a row");

    // products in flight at a flush never complete
    for (genvar k = 1; k <= LATENCY; k++) begin : g_flush
        a_no_done_after_flush: assert property (
            @(posedge clk) disable iff (!rst_n)
            mul_done_i |-> !$past(flush_i, k)
        ) else $error("multiply done %0d cycles after a flush", k);
    end

    a_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown({res_i, less_i, zero_i, mul_done_i})
    ) else $error("unknown value on an output");

endmodule

bind rv64_alu_top rv64_alu_assertions #(
    .NUM_STAGES (NUM_STAGES)
) u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .issued_i   (chain[0].valid),
    .mul_done_i (mul_done_o),
    .res_i      (res_o),
    .less_i     (less_o),
    .zero_i     (zero_o)
);

// ==== rv64_alu_pkg.sv ====
package rv64_alu_pkg;

    // datapath width of the integer unit
    localparam int XLEN = 64;

    // full product width of the multiplier
    localparam int PROD_W = 2 * XLEN;

    // alu operation
    // low three bits pick the result source, bit 3 selects the variant
    // (sub vs add, unsigned vs signed compare, arithmetic vs logical shift)
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SLL  = 4'h1,
        ALU_SLT  = 4'h2,
        ALU_SRC2 = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SRL  = 4'h5,
        ALU_OR   = 4'h6,
        ALU_AND  = 4'h7,
        ALU_SUB  = 4'h8,
        ALU_SLTU = 4'hA,
        ALU_SRA  = 4'hD
    } alu_op_e;

    // multiply type, same order as funct3 of mul/mulh/mulhsu/mulhu
    typedef enum logic [1:0] {
        // low half, mul and mulw
        MUL_LO  = 2'd0,
        // high half, signed x signed
        MUL_HSS = 2'd1,
        // high half, signed x unsigned
        MUL_HSU = 2'd2,
        // high half, unsigned x unsigned
        MUL_HUU = 2'd3
    } mul_op_e;

    // payload carried down the multiplier pipeline
    typedef struct packed {
        // product in flight
        logic              valid;
        // which half goes out
        mul_op_e           op;
        // 32-bit form, result sign-extended from bit 31
        logic              word;
        // operand signs differ, negate at the end
        logic              neg;
        // absolute multiplicand
        logic [XLEN-1:0]   mcand;
        // absolute multiplier, consumed from the lsb
        logic [XLEN-1:0]   mplier;
        // partial product
        logic [PROD_W-1:0] acc;
    } mul_pipe_t;

endpackage

// ==== rv64_alu_top.sv ====
`timescale 1ns/1ps

module rv64_alu_top
    import rv64_alu_pkg::*;
#(
    parameter int NUM_STAGES = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  alu_op_e         alu_op_i,
    input  logic            word_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    input  logic            mul_en_i,
    input  mul_op_e         mul_op_i,
    input  logic            flush_i,
    output logic [XLEN-1:0] res_o,
    output logic            less_o,
    output logic            zero_o,
    output logic            mul_done_o
);

    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] mul_res;
    // chain[0] from prep, chain[NUM_STAGES] into finish
    mul_pipe_t       chain [0:NUM_STAGES];

    alu_core u_alu_core (
        .op_i   (alu_op_i),
        .word_i (word_i),
        .src1_i (src1_i),
        .src2_i (src2_i),
        .res_o  (alu_res),
        .less_o (less_o),
        .zero_o (zero_o)
    );

    mul_prep u_mul_prep (
        .clk     (clk),
        .rst_n   (rst_n),
        .en_i    (mul_en_i),
        .op_i    (mul_op_i),
        .word_i  (word_i),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .flush_i (flush_i),
        .pipe_o  (chain[0])
    );

    for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
        mul_stage #(
            .NUM_STAGES (NUM_STAGES)
        ) u_mul_stage (
            .clk     (clk),
            .rst_n   (rst_n),
            .flush_i (flush_i),
            .pipe_i  (chain[g]),
            .pipe_o  (chain[g+1])
        );
    end

    mul_finish u_mul_finish (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush_i  (flush_i),
        .pipe_i   (chain[NUM_STAGES]),
        .result_o (mul_res),
        .done_o   (mul_done_o)
    );

    // multiplier result while a multiply is requested
    assign res_o = mul_en_i ? mul_res : alu_res;

endmodule

// ==== rv64_alu_vectors.txt ====
// columns: kind op word src1 src2 expected_result expected_less
// kind 0 alu, 1 multiply, f ends the list; op is alu_op_e or mul_op_e; less 2 is not checked
0 0 0 0000000000000005 0000000000000003 0000000000000008 2
0 0 1 000000007fffffff 0000000000000001 ffffffff80000000 2
0 8 0 0000000000001234 0000000000001234 0000000000000000 0
0 8 1 0000000100000000 0000000000000001 ffffffffffffffff 0
0 8 0 0000000000000003 0000000000000005 fffffffffffffffe 1
0 1 0 0000000000000001 000000000000003f 8000000000000000 2
0 1 1 0000000000000003 000000000000003f ffffffff80000000 2
0 2 0 8000000000000000 0000000000000001 0000000000000001 1
0 2 1 0000000000000005 fffffffffffffffb 0000000000000000 0
0 a 0 8000000000000000 0000000000000001 0000000000000000 0
0 a 1 0000000000000001 fffffffffffffffb 0000000000000001 1
0 3 0 1111111111111111 123456789abcdef0 123456789abcdef0 2
0 3 1 1111111111111111 123456789abcdef0 ffffffff9abcdef0 2
0 4 0 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 0ff00ff00ff00ff0 2
0 4 1 00000000ffff0000 000000000000ffff ffffffffffffffff 2
0 5 0 8000000000000000 0000000000000004 0800000000000000 2
0 5 1 ffffffff80000000 0000000000000024 0000000008000000 2
0 d 0 8000000000000000 0000000000000004 f800000000000000 2
0 d 1 0000000080000000 0000000000000004 fffffffff8000000 2
0 6 0 f000000000000000 000000000000000f f00000000000000f 2
0 6 1 0000000000000f00 0000000070000000 0000000070000f00 2
0 7 0 ffff0000ffff0000 0ff00ff00ff00ff0 0ff000000ff00000 2
0 7 1 ffffffff80000000 00000000ffffffff ffffffff80000000 2
1 0 0 fffffffffffffffd 0000000000000007 ffffffffffffffeb 2
1 1 0 8000000000000000 8000000000000000 4000000000000000 2
1 2 0 ffffffffffffffff ffffffffffffffff ffffffffffffffff 2
1 3 0 ffffffffffffffff ffffffffffffffff fffffffffffffffe 2
1 0 1 0000000000010000 0000000000008000 ffffffff80000000 2
1 0 0 0000000100000001 0000000100000001 0000000200000001 2
1 1 0 fffffffffffffffe 7fffffffffffffff ffffffffffffffff 2
f 0 0 0000000000000000 0000000000000000 0000000000000000 0

// ==== tb_rv64_alu.sv ====
`timescale 1ns/1ps

module tb_rv64_alu
    import rv64_alu_pkg::*;
();

    localparam int NUM_STAGES = 4;
    localparam int LATENCY    = NUM_STAGES + 2;
    localparam int MAX_VEC    = 64;
    localparam int REC_WORDS  = 7;
    localparam int WAIT_LIMIT = 4 * LATENCY + 20;

    typedef struct packed {
        logic [3:0]      kind;
        logic [3:0]      op;
        logic            word;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
        logic [XLEN-1:0] res;
        logic [1:0]      less;
    } vec_t;

    logic            clk;
    logic            rst_n;
    alu_op_e         alu_op;
    logic            word;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic            mul_en;
    mul_op_e         mul_op;
    logic            flush;
    logic [XLEN-1:0] res;
    logic            less;
    logic            zero;
    logic            mul_done;

    logic [XLEN-1:0] mem [0:MAX_VEC*REC_WORDS-1];
    vec_t            alu_vecs [$];
    vec_t            mul_vecs [$];

    rv64_alu_top #(
        .NUM_STAGES (NUM_STAGES)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_op_i   (alu_op),
        .word_i     (word),
        .src1_i     (src1),
        .src2_i     (src2),
        .mul_en_i   (mul_en),
        .mul_op_i   (mul_op),
        .flush_i    (flush),
        .res_o      (res),
        .less_o     (less),
        .zero_o     (zero),
        .mul_done_o (mul_done)
    );

    always #5 clk = ~clk;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic load_vectors();
        vec_t v;
        int   base;
        logic found;
        found = 1'b0;
        $readmemh("rv64_alu_vectors.txt", mem);
        for (int i = 0; i < MAX_VEC; i++) begin
            base = i * REC_WORDS;
            if (mem[base] == 64'hf) begin
                found = 1'b1;
                break;
            end
            v.kind = mem[base][3:0];
            v.op   = mem[base+1][3:0];
            v.word = mem[base+2][0];
            v.src1 = mem[base+3];
            v.src2 = mem[base+4];
            v.res  = mem[base+5];
            v.less = mem[base+6][1:0];
            if (v.kind == 4'd0) begin
                alu_vecs.push_back(v);
            end else if (v.kind == 4'd1) begin
                mul_vecs.push_back(v);
            end else begin
                stop_with_error("vector file holds a record of unknown kind");
            end
        end
        if (!found || alu_vecs.size() == 0 || mul_vecs.size() < 2) begin
            stop_with_error("vector file is missing records or its end marker");
        end
    endtask

    task automatic drive_alu(input vec_t v);
        alu_op = alu_op_e'(v.op);
        word   = v.word;
        src1   = v.src1;
        src2   = v.src2;
        mul_en = 1'b0;
    endtask

    task automatic drive_mul(input vec_t v);
        mul_op = mul_op_e'(v.op[1:0]);
        word   = v.word;
        src1   = v.src1;
        src2   = v.src2;
        mul_en = 1'b1;
    endtask

    // combinational result, checked before the next rising edge
    task automatic run_alu_tests();
        string name;
        foreach (alu_vecs[i]) begin
            @(negedge clk);
            drive_alu(alu_vecs[i]);
            @(posedge clk);
            name = $sformatf("alu vector %0d", i);
            check_value({name, " result"}, alu_vecs[i].res, res);
            if (alu_vecs[i].less != 2'd2) begin
                check_value({name, " less"}, XLEN'(alu_vecs[i].less), XLEN'(less));
            end
            // adder zero flag, only the full-width add and sub expose the raw sum
            if ((alu_vecs[i].op == ALU_ADD || alu_vecs[i].op == ALU_SUB) && !alu_vecs[i].word) begin
                check_value({name, " zero"}, XLEN'(alu_vecs[i].res == '0), XLEN'(zero));
            end
        end
    endtask

    // one issue, operands held for the whole window
    task automatic run_mul_single(input vec_t v, input string name);
        int              first;
        int              pulses;
        logic [XLEN-1:0] got;
        first  = -1;
        pulses = 0;
        got    = '0;
        @(negedge clk);
        drive_mul(v);
        for (int n = 0; n < 2 * LATENCY; n++) begin
            @(negedge clk);
            if (mul_done) begin
                pulses++;
                if (first < 0) begin
                    first = n;
                    got   = res;
                end
            end
        end
        if (pulses == 0) begin
            stop_with_error($sformatf("timeout, no multiply done for %s", name));
        end
        check_value({name, " latency"}, XLEN'(LATENCY), XLEN'(first));
        check_value({name, " pulses"}, XLEN'(1), XLEN'(pulses));
        check_value({name, " result"}, v.res, got);
    endtask

    // new operands every cycle, one pulse per issue in order
    task automatic run_back_to_back();
        int idx;
        int got;
        int cyc;
        @(negedge clk);
        drive_mul(mul_vecs[0]);
        idx = 1;
        got = 0;
        cyc = 0;
        while (got < mul_vecs.size()) begin
            @(negedge clk);
            if (mul_done) begin
                check_value($sformatf("back-to-back %0d cycle", got),
                            XLEN'(LATENCY + got), XLEN'(cyc));
                check_value($sformatf("back-to-back %0d result", got), mul_vecs[got].res, res);
                got++;
            end
            if (idx < mul_vecs.size()) begin
                drive_mul(mul_vecs[idx]);
                idx++;
            end
            cyc++;
            if (cyc > WAIT_LIMIT) begin
                stop_with_error("timeout waiting for back-to-back multiply results");
            end
        end
    endtask

    task automatic run_flush();
        vec_t v;
        v = mul_vecs[0];
        @(negedge clk);
        drive_mul(v);
        @(negedge clk);
        @(negedge clk);
        // sampled on the second edge after issue
        flush  = 1'b1;
        mul_en = 1'b0;
        @(negedge clk);
        flush = 1'b0;
        for (int n = 0; n < 2 * LATENCY; n++) begin
            @(negedge clk);
            if (mul_done) begin
                stop_with_error("a flushed multiply still signalled done");
            end
        end
        run_mul_single(v, "reissue after flush");
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        alu_op = ALU_ADD;
        word   = 1'b0;
        src1   = '0;
        src2   = '0;
        mul_en = 1'b0;
        mul_op = MUL_LO;
        flush  = 1'b0;
        load_vectors();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("done after reset", '0, XLEN'(mul_done));
        run_alu_tests();
        foreach (mul_vecs[i]) begin
            run_mul_single(mul_vecs[i], $sformatf("mul vector %0d", i));
        end
        run_back_to_back();
        run_flush();
        @(negedge clk);
        mul_en = 1'b0;
        $display("=== PASS ===");
        $finish;
    end

endmodule
